// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path width
`define CPU_XLEN 32

// register file address, 32 registers
`define CPU_REG_AW 5

// instruction memory word address
`define CPU_IM_AW 10

// data memory word address
`define CPU_DM_AW 10

`endif

// File: source/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

	// primary opcode, top six bits of the word
	typedef enum logic [5:0] {
		alu_r = 6'd0,
		addi  = 6'd1,
		ori   = 6'd2,
		lw    = 6'd3,
		sw    = 6'd4
	} opcode_t;

	// function field of alu_r
	typedef enum logic [4:0] {
		add    = 5'd0,
		sub    = 5'd1,
		and_op = 5'd2,
		or_op  = 5'd3,
		xor_op = 5'd4
	} alu_fn_t;

	typedef struct packed {
		opcode_t                opcode;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] ra;
		logic [`CPU_REG_AW-1:0] rb;
		logic [5:0]             unused;
		alu_fn_t                fn;
	} r_fmt_t;

	typedef struct packed {
		opcode_t                opcode;
		logic [`CPU_REG_AW-1:0] rt;
		logic [`CPU_REG_AW-1:0] ra;
		logic [15:0]            imm;
	} i_fmt_t;

	// all-zero word is add r0, r0, r0
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module alu (
	input  logic [`CPU_XLEN-1:0] src1,
	input  logic [`CPU_XLEN-1:0] rb_data,
	input  logic [`CPU_XLEN-1:0] imm_ext,
	input  logic                 use_imm,
	input  cpu_pkg::alu_fn_t     alu_fn,
	input  logic                 overflow_check,
	output logic [`CPU_XLEN-1:0] result,
	output logic                 overflow
);
	localparam int MSB = `CPU_XLEN - 1;

	logic [`CPU_XLEN-1:0] src2;
	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] diff;
	logic                 add_ovf;
	logic                 sub_ovf;

	assign src2 = use_imm ? imm_ext : rb_data;
	assign sum  = src1 + src2;
	assign diff = src1 - src2;

	// same operand signs, result sign flipped
	assign add_ovf = (src1[MSB] == src2[MSB]) && (sum[MSB] != src1[MSB]);
	// operand signs differ, result takes sign of src2
	assign sub_ovf = (src1[MSB] != src2[MSB]) && (diff[MSB] != src1[MSB]);

	always_comb begin
		case (alu_fn)
			cpu_pkg::add:    result = sum;
			cpu_pkg::sub:    result = diff;
			cpu_pkg::and_op: result = src1 & src2;
			cpu_pkg::or_op:  result = src1 | src2;
			cpu_pkg::xor_op: result = src1 ^ src2;
			default:         result = '0;
		endcase
	end

	always_comb begin
		overflow = 1'b0;
		if (overflow_check) begin
			case (alu_fn)
				cpu_pkg::add: overflow = add_ovf;
				cpu_pkg::sub: overflow = sub_ovf;
				default:      overflow = 1'b0;
			endcase
		end
	end

endmodule

// File: source/regfile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regfile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_REG_AW-1:0] ra_addr,
	input  logic [`CPU_REG_AW-1:0] rb_addr,
	input  logic [`CPU_REG_AW-1:0] rt_addr,
	input  logic [`CPU_REG_AW-1:0] write_addr,
	input  logic [`CPU_XLEN-1:0]   write_data,
	input  logic                   write_en,
	output logic [`CPU_XLEN-1:0]   ra_data,
	output logic [`CPU_XLEN-1:0]   rb_data,
	output logic [`CPU_XLEN-1:0]   rt_data
);
	localparam int NREGS = 1 << `CPU_REG_AW;

	logic [`CPU_XLEN-1:0] regs [0:NREGS-1];

	// r0 reads zero, a same-cycle write is passed through
	function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_REG_AW-1:0] addr);
		logic [`CPU_XLEN-1:0] value;
		if (addr == '0)
			value = '0;
		else if (write_en && write_addr == addr)
			value = write_data;
		else
			value = regs[addr];
		return value;
	endfunction

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
		rt_data = read_port(rt_addr);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

// File: source/controller.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module controller (
	input  logic [31:0]            if_instruction,
	input  logic [`CPU_REG_AW-1:0] ex_rt,
	input  logic                   ex_reg_write,
	input  logic [`CPU_REG_AW-1:0] mem_rt,
	input  logic                   mem_reg_write,
	output logic [`CPU_REG_AW-1:0] ra_addr,
	output logic [`CPU_REG_AW-1:0] rb_addr,
	output logic [`CPU_REG_AW-1:0] rt_addr,
	output cpu_pkg::alu_fn_t       alu_fn,
	output logic                   use_imm,
	output logic [`CPU_XLEN-1:0]   imm_ext,
	output logic                   is_load,
	output logic                   is_store,
	output logic                   reg_write,
	output logic                   overflow_check,
	output logic                   stall
);
	cpu_pkg::instr_u        instr;
	logic                   fn_valid;
	logic [`CPU_REG_AW-1:0] store_src;
	logic                   ex_hit;
	logic                   mem_hit;

	assign instr = if_instruction;

	always_comb begin
		case (instr.r_fmt.fn)
			cpu_pkg::add, cpu_pkg::sub, cpu_pkg::and_op,
			cpu_pkg::or_op, cpu_pkg::xor_op: fn_valid = 1'b1;
			default:                         fn_valid = 1'b0;
		endcase
	end

	// ori zero extends, everything else sign extends
	assign imm_ext = (instr.i_fmt.opcode == cpu_pkg::ori) ?
		{{(`CPU_XLEN-16){1'b0}}, instr.i_fmt.imm} :
		{{(`CPU_XLEN-16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};

	always_comb begin
		ra_addr        = '0;
		rb_addr        = '0;
		rt_addr        = instr.r_fmt.rt;
		alu_fn         = cpu_pkg::add;
		use_imm        = 1'b0;
		is_load        = 1'b0;
		is_store       = 1'b0;
		reg_write      = 1'b0;
		overflow_check = 1'b0;
		case (instr.r_fmt.opcode)
			cpu_pkg::alu_r: begin
				// bad function code decodes as nop
				if (fn_valid) begin
					ra_addr        = instr.r_fmt.ra;
					rb_addr        = instr.r_fmt.rb;
					alu_fn         = instr.r_fmt.fn;
					reg_write      = 1'b1;
					overflow_check = (instr.r_fmt.fn == cpu_pkg::add) ||
						(instr.r_fmt.fn == cpu_pkg::sub);
				end
			end
			cpu_pkg::addi: begin
				ra_addr        = instr.i_fmt.ra;
				use_imm        = 1'b1;
				reg_write      = 1'b1;
				overflow_check = 1'b1;
			end
			cpu_pkg::ori: begin
				ra_addr   = instr.i_fmt.ra;
				alu_fn    = cpu_pkg::or_op;
				use_imm   = 1'b1;
				reg_write = 1'b1;
			end
			// address is ra + imm
			cpu_pkg::lw: begin
				ra_addr   = instr.i_fmt.ra;
				use_imm   = 1'b1;
				is_load   = 1'b1;
				reg_write = 1'b1;
			end
			cpu_pkg::sw: begin
				ra_addr  = instr.i_fmt.ra;
				use_imm  = 1'b1;
				is_store = 1'b1;
			end
			default: ;
		endcase
	end

	// store data comes from rt, so it is a source too
	assign store_src = is_store ? rt_addr : '0;

	assign ex_hit = ex_reg_write && (ex_rt != '0) &&
		(ex_rt == ra_addr || ex_rt == rb_addr || ex_rt == store_src);
	assign mem_hit = mem_reg_write && (mem_rt != '0) &&
		(mem_rt == ra_addr || mem_rt == rb_addr || mem_rt == store_src);

	assign stall = ex_hit | mem_hit;

endmodule

// File: source/regwalls.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regwalls (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic [31:0]            instruction,
	input  logic [`CPU_REG_AW-1:0] rt_addr,
	input  cpu_pkg::alu_fn_t       alu_fn,
	input  logic                   use_imm,
	input  logic [`CPU_XLEN-1:0]   imm_ext,
	input  logic                   is_load,
	input  logic                   is_store,
	input  logic                   reg_write,
	input  logic                   overflow_check,
	input  logic [`CPU_XLEN-1:0]   ra_data,
	input  logic [`CPU_XLEN-1:0]   rb_data,
	input  logic [`CPU_XLEN-1:0]   rt_data,
	input  logic [`CPU_XLEN-1:0]   alu_result,
	input  logic                   alu_overflow_in,
	input  logic [`CPU_XLEN-1:0]   dm_out,
	output logic [`CPU_IM_AW-1:0]  im_address,
	output logic [31:0]            if_instruction,
	output logic [`CPU_XLEN-1:0]   ex_ra_data,
	output logic [`CPU_XLEN-1:0]   ex_rb_data,
	output logic [`CPU_XLEN-1:0]   ex_imm_ext,
	output logic                   ex_use_imm,
	output cpu_pkg::alu_fn_t       ex_alu_fn,
	output logic                   ex_overflow_check,
	output logic [`CPU_REG_AW-1:0] ex_rt,
	output logic                   ex_reg_write,
	output logic [`CPU_REG_AW-1:0] mem_rt,
	output logic                   mem_reg_write,
	output logic                   dm_read,
	output logic                   dm_write,
	output logic [`CPU_DM_AW-1:0]  dm_address,
	output logic [`CPU_XLEN-1:0]   dm_in,
	output logic [`CPU_REG_AW-1:0] write_addr,
	output logic [`CPU_XLEN-1:0]   write_data,
	output logic                   write_en,
	output logic                   alu_overflow
);
	logic [`CPU_XLEN-1:0] ex_rt_data;
	logic                 ex_is_load;
	logic                 ex_is_store;
	logic [`CPU_XLEN-1:0] mem_result;

	// pc and IF/ID, both hold on stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			im_address     <= '0;
			if_instruction <= '0;
		end else if (!stall) begin
			im_address     <= im_address + 1'b1;
			if_instruction <= instruction;
		end
	end

	// ID/EX, control cleared on stall to form a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_ra_data        <= '0;
			ex_rb_data        <= '0;
			ex_rt_data        <= '0;
			ex_imm_ext        <= '0;
			ex_use_imm        <= 1'b0;
			ex_alu_fn         <= cpu_pkg::add;
			ex_rt             <= '0;
			ex_reg_write      <= 1'b0;
			ex_is_load        <= 1'b0;
			ex_is_store       <= 1'b0;
			ex_overflow_check <= 1'b0;
		end else begin
			ex_ra_data        <= ra_data;
			ex_rb_data        <= rb_data;
			ex_rt_data        <= rt_data;
			ex_imm_ext        <= imm_ext;
			ex_use_imm        <= use_imm;
			ex_alu_fn         <= alu_fn;
			ex_rt             <= rt_addr;
			ex_reg_write      <= reg_write & ~stall;
			ex_is_load        <= is_load & ~stall;
			ex_is_store       <= is_store & ~stall;
			ex_overflow_check <= overflow_check & ~stall;
		end
	end

	// EX/MEM and the sticky overflow flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_result    <= '0;
			mem_rt        <= '0;
			mem_reg_write <= 1'b0;
			dm_read       <= 1'b0;
			dm_write      <= 1'b0;
			dm_in         <= '0;
			alu_overflow  <= 1'b0;
		end else begin
			mem_result    <= alu_result;
			mem_rt        <= ex_rt;
			mem_reg_write <= ex_reg_write;
			dm_read       <= ex_is_load;
			dm_write      <= ex_is_store;
			dm_in         <= ex_rt_data;
			if (alu_overflow_in)
				alu_overflow <= 1'b1;
		end
	end

	// result is already a word address
	assign dm_address = mem_result[`CPU_DM_AW-1:0];

	// MEM/WB, load data only valid during the read cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			write_addr <= '0;
			write_data <= '0;
			write_en   <= 1'b0;
		end else begin
			write_addr <= mem_rt;
			write_data <= dm_read ? dm_out : mem_result;
			write_en   <= mem_reg_write;
		end
	end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           instruction,
	input  logic [`CPU_XLEN-1:0]  dm_out,
	output logic [`CPU_IM_AW-1:0] im_address,
	output logic                  dm_read,
	output logic                  dm_write,
	output logic [`CPU_DM_AW-1:0] dm_address,
	output logic [`CPU_XLEN-1:0]  dm_in,
	output logic                  alu_overflow
);
	// decode stage
	logic [31:0]            if_instruction;
	logic [`CPU_REG_AW-1:0] ra_addr;
	logic [`CPU_REG_AW-1:0] rb_addr;
	logic [`CPU_REG_AW-1:0] rt_addr;
	cpu_pkg::alu_fn_t       alu_fn;
	logic                   use_imm;
	logic [`CPU_XLEN-1:0]   imm_ext;
	logic                   is_load;
	logic                   is_store;
	logic                   reg_write;
	logic                   overflow_check;
	logic                   stall;
	logic [`CPU_XLEN-1:0]   ra_data;
	logic [`CPU_XLEN-1:0]   rb_data;
	logic [`CPU_XLEN-1:0]   rt_data;

	// execute stage
	logic [`CPU_XLEN-1:0]   ex_ra_data;
	logic [`CPU_XLEN-1:0]   ex_rb_data;
	logic [`CPU_XLEN-1:0]   ex_imm_ext;
	logic                   ex_use_imm;
	cpu_pkg::alu_fn_t       ex_alu_fn;
	logic                   ex_overflow_check;
	logic [`CPU_REG_AW-1:0] ex_rt;
	logic                   ex_reg_write;
	logic [`CPU_XLEN-1:0]   alu_result;
	logic                   alu_overflow_ex;

	// memory and write-back
	logic [`CPU_REG_AW-1:0] mem_rt;
	logic                   mem_reg_write;
	logic [`CPU_REG_AW-1:0] write_addr;
	logic [`CPU_XLEN-1:0]   write_data;
	logic                   write_en;

	controller i_controller (
		.if_instruction (if_instruction),
		.ex_rt          (ex_rt),
		.ex_reg_write   (ex_reg_write),
		.mem_rt         (mem_rt),
		.mem_reg_write  (mem_reg_write),
		.ra_addr        (ra_addr),
		.rb_addr        (rb_addr),
		.rt_addr        (rt_addr),
		.alu_fn         (alu_fn),
		.use_imm        (use_imm),
		.imm_ext        (imm_ext),
		.is_load        (is_load),
		.is_store       (is_store),
		.reg_write      (reg_write),
		.overflow_check (overflow_check),
		.stall          (stall)
	);

	regfile i_regfile (
		.clk        (clk),
		.rst_n      (rst_n),
		.ra_addr    (ra_addr),
		.rb_addr    (rb_addr),
		.rt_addr    (rt_addr),
		.write_addr (write_addr),
		.write_data (write_data),
		.write_en   (write_en),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.rt_data    (rt_data)
	);

	alu i_alu (
		.src1           (ex_ra_data),
		.rb_data        (ex_rb_data),
		.imm_ext        (ex_imm_ext),
		.use_imm        (ex_use_imm),
		.alu_fn         (ex_alu_fn),
		.overflow_check (ex_overflow_check),
		.result         (alu_result),
		.overflow       (alu_overflow_ex)
	);

	regwalls i_regwalls (
		.clk               (clk),
		.rst_n             (rst_n),
		.stall             (stall),
		.instruction       (instruction),
		.rt_addr           (rt_addr),
		.alu_fn            (alu_fn),
		.use_imm           (use_imm),
		.imm_ext           (imm_ext),
		.is_load           (is_load),
		.is_store          (is_store),
		.reg_write         (reg_write),
		.overflow_check    (overflow_check),
		.ra_data           (ra_data),
		.rb_data           (rb_data),
		.rt_data           (rt_data),
		.alu_result        (alu_result),
		.alu_overflow_in   (alu_overflow_ex),
		.dm_out            (dm_out),
		.im_address        (im_address),
		.if_instruction    (if_instruction),
		.ex_ra_data        (ex_ra_data),
		.ex_rb_data        (ex_rb_data),
		.ex_imm_ext        (ex_imm_ext),
		.ex_use_imm        (ex_use_imm),
		.ex_alu_fn         (ex_alu_fn),
		.ex_overflow_check (ex_overflow_check),
		.ex_rt             (ex_rt),
		.ex_reg_write      (ex_reg_write),
		.mem_rt            (mem_rt),
		.mem_reg_write     (mem_reg_write),
		.dm_read           (dm_read),
		.dm_write          (dm_write),
		.dm_address        (dm_address),
		.dm_in             (dm_in),
		.write_addr        (write_addr),
		.write_data        (write_data),
		.write_en          (write_en),
		.alu_overflow      (alu_overflow)
	);

endmodule

// File: test/cpu_properties.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_properties (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  stall,
	input logic [`CPU_IM_AW-1:0] im_address,
	input logic                  dm_read,
	input logic                  dm_write,
	input logic                  alu_overflow
);
	// one memory strobe at a time
	strobes_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n) !(dm_read && dm_write)
	) else $error("dm_read and dm_write are high in the same cycle");

	reset_quiet: assert property (
		@(posedge clk) !rst_n |-> (!dm_read && !dm_write && !alu_overflow)
	) else $error("memory strobes or overflow flag active during reset");

	// a stalled decode keeps the fetch address
	pc_holds_on_stall: assert property (
		@(posedge clk) disable iff (!rst_n) stall |=> $stable(im_address)
	) else $error("im_address moved while stall was high");

	overflow_sticky: assert property (
		@(posedge clk) disable iff (!rst_n) alu_overflow |=> alu_overflow
	) else $error("alu_overflow fell without a reset");

endmodule

bind cpu_top cpu_properties i_cpu_properties (
	.clk          (clk),
	.rst_n        (rst_n),
	.stall        (stall),
	.im_address   (im_address),
	.dm_read      (dm_read),
	.dm_write     (dm_write),
	.alu_overflow (alu_overflow)
);

// File: test/cpu_checker.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_checker #(
	parameter int PROG_WORDS = 96
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  prog_ready,
	input  logic [31:0]           program_words [0:PROG_WORDS-1],
	input  logic                  dm_read,
	input  logic                  dm_write,
	input  logic [`CPU_DM_AW-1:0] dm_address,
	input  logic [`CPU_XLEN-1:0]  dm_in,
	input  logic                  alu_overflow,
	input  logic                  end_run,
	output logic                  stores_done,
	output logic                  report_done,
	output int                    error_count
);
	localparam int DM_WORDS = 1 << `CPU_DM_AW;
	localparam int NREGS = 1 << `CPU_REG_AW;

	logic [`CPU_XLEN-1:0]  model_regs [0:NREGS-1];
	logic [`CPU_XLEN-1:0]  model_mem [0:DM_WORDS-1];
	logic [`CPU_DM_AW-1:0] exp_addr [$];
	logic [`CPU_XLEN-1:0]  exp_data [$];
	logic [`CPU_DM_AW-1:0] exp_load [$];
	logic                  exp_overflow = 1'b0;
	logic                  model_ready = 1'b0;
	int                    expected_total = 0;
	int                    expected_loads = 0;
	int                    stores_seen = 0;
	int                    loads_seen = 0;
	int                    mismatch_count = 0;
	int                    extra_count = 0;

	// exact signed result out of the 32-bit range
	function automatic bit signed_overflow(input logic [31:0] a, input logic [31:0] b,
		input bit subtract);
		longint exact;
		if (subtract)
			exact = longint'($signed(a)) - longint'($signed(b));
		else
			exact = longint'($signed(a)) + longint'($signed(b));
		return (exact > 64'sd2147483647) || (exact < -64'sd2147483648);
	endfunction

	task automatic write_reg(input logic [`CPU_REG_AW-1:0] rt, input logic [31:0] value);
		if (rt != '0)
			model_regs[rt] = value;
	endtask

	task automatic run_model();
		cpu_pkg::instr_u       word;
		logic [`CPU_XLEN-1:0]  a;
		logic [`CPU_XLEN-1:0]  b;
		logic [`CPU_XLEN-1:0]  imm_s;
		logic [`CPU_XLEN-1:0]  imm_z;
		logic [`CPU_XLEN-1:0]  sum;
		logic [`CPU_DM_AW-1:0] addr;
		for (int r = 0; r < NREGS; r++)
			model_regs[r] = '0;
		for (int k = 0; k < DM_WORDS; k++)
			model_mem[k] = k ^ 32'h5a5a0000;
		for (int pc = 0; pc < PROG_WORDS; pc++) begin
			word  = program_words[pc];
			a     = model_regs[word.i_fmt.ra];
			b     = model_regs[word.r_fmt.rb];
			imm_s = {{16{word.i_fmt.imm[15]}}, word.i_fmt.imm};
			imm_z = {16'h0000, word.i_fmt.imm};
			sum   = a + imm_s;
			addr  = sum[`CPU_DM_AW-1:0];
			case (word.r_fmt.opcode)
				cpu_pkg::alu_r: begin
					case (word.r_fmt.fn)
						cpu_pkg::add: begin
							write_reg(word.r_fmt.rt, a + b);
							exp_overflow |= signed_overflow(a, b, 1'b0);
						end
						cpu_pkg::sub: begin
							write_reg(word.r_fmt.rt, a - b);
							exp_overflow |= signed_overflow(a, b, 1'b1);
						end
						cpu_pkg::and_op: write_reg(word.r_fmt.rt, a & b);
						cpu_pkg::or_op:  write_reg(word.r_fmt.rt, a | b);
						cpu_pkg::xor_op: write_reg(word.r_fmt.rt, a ^ b);
						default: ;
					endcase
				end
				cpu_pkg::addi: begin
					write_reg(word.i_fmt.rt, sum);
					exp_overflow |= signed_overflow(a, imm_s, 1'b0);
				end
				cpu_pkg::ori: write_reg(word.i_fmt.rt, a | imm_z);
				cpu_pkg::lw: begin
					write_reg(word.i_fmt.rt, model_mem[addr]);
					exp_load.push_back(addr);
				end
				cpu_pkg::sw: begin
					model_mem[addr] = model_regs[word.i_fmt.rt];
					exp_addr.push_back(addr);
					exp_data.push_back(model_regs[word.i_fmt.rt]);
				end
				default: ;
			endcase
		end
		expected_total = exp_addr.size();
		expected_loads = exp_load.size();
	endtask

	assign stores_done = model_ready && (stores_seen == expected_total);

	// strobes and store data settle after the rising edge
	always @(negedge clk) begin
		logic [`CPU_DM_AW-1:0] want_addr;
		logic [`CPU_XLEN-1:0]  want_data;
		if (rst_n && dm_read) begin
			if (exp_load.size() == 0) begin
				$display("unexpected load from address 0x%03h after all expected loads",
					dm_address);
				extra_count++;
			end else begin
				want_addr = exp_load.pop_front();
				if (dm_address !== want_addr) begin
					$display("ERROR load_address[%0d]: expected 0x%03h, actual 0x%03h",
						loads_seen, want_addr, dm_address);
					mismatch_count++;
				end
				loads_seen++;
			end
		end
		if (rst_n && dm_write) begin
			if (exp_addr.size() == 0) begin
				$display("unexpected store to address 0x%03h after all expected stores",
					dm_address);
				extra_count++;
			end else begin
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				if (dm_address !== want_addr) begin
					$display("ERROR store_address[%0d]: expected 0x%03h, actual 0x%03h",
						stores_seen, want_addr, dm_address);
					mismatch_count++;
				end
				if (dm_in !== want_data) begin
					$display("ERROR store_data[%0d]: expected 0x%08h, actual 0x%08h",
						stores_seen, want_data, dm_in);
					mismatch_count++;
				end
				stores_seen++;
			end
		end
	end

	initial begin
		int missing;
		int missing_loads;
		int overflow_errors;
		report_done = 1'b0;
		error_count = 0;
		overflow_errors = 0;
		wait (prog_ready);
		run_model();
		model_ready = 1'b1;
		wait (end_run);
		missing = expected_total - stores_seen;
		missing_loads = expected_loads - loads_seen;
		if (missing != 0)
			$display("only %0d of %0d expected stores reached the data port",
				stores_seen, expected_total);
		if (missing_loads != 0)
			$display("only %0d of %0d expected loads reached the data port",
				loads_seen, expected_loads);
		if (alu_overflow !== exp_overflow) begin
			$display("ERROR final_overflow: expected %0b, actual %0b",
				exp_overflow, alu_overflow);
			overflow_errors = 1;
		end
		error_count = mismatch_count + extra_count + missing + missing_loads +
			overflow_errors;
		$write("mismatches %0d, extra accesses %0d, missing stores %0d, ",
			mismatch_count, extra_count, missing);
		$display("missing loads %0d, overflow errors %0d, total %0d",
			missing_loads, overflow_errors, error_count);
		report_done = 1'b1;
	end

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb;
	localparam int PROG_WORDS = 96;
	localparam int RANDOM_WORDS = 80;
	localparam int RESET_CYCLES = 8;
	localparam int DM_WORDS = 1 << `CPU_DM_AW;
	// pipeline is empty once fetch is this far past the program
	localparam int DRAIN_PC = PROG_WORDS + 4;
	// three cycles per word at worst, plus reset, drain and margin
	localparam int TIMEOUT_CYCLES = PROG_WORDS * 3 + RESET_CYCLES + 104;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic [31:0]           instruction = '0;
	logic [`CPU_XLEN-1:0]  dm_out = '0;
	logic [`CPU_IM_AW-1:0] im_address;
	logic                  dm_read;
	logic                  dm_write;
	logic [`CPU_DM_AW-1:0] dm_address;
	logic [`CPU_XLEN-1:0]  dm_in;
	logic                  alu_overflow;

	logic [31:0]           program_words [0:PROG_WORDS-1];
	logic [`CPU_XLEN-1:0]  data_mem [0:DM_WORDS-1];
	logic [31:0]           lfsr_state = 32'h2191;
	logic                  prog_ready = 1'b0;
	logic                  end_run = 1'b0;
	logic                  timed_out = 1'b0;
	logic                  stores_done;
	logic                  report_done;
	int                    error_count;
	int                    cycle_count = 0;

	cpu_top i_cpu_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.instruction  (instruction),
		.dm_out       (dm_out),
		.im_address   (im_address),
		.dm_read      (dm_read),
		.dm_write     (dm_write),
		.dm_address   (dm_address),
		.dm_in        (dm_in),
		.alu_overflow (alu_overflow)
	);

	cpu_checker #(.PROG_WORDS(PROG_WORDS)) i_cpu_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.prog_ready    (prog_ready),
		.program_words (program_words),
		.dm_read       (dm_read),
		.dm_write      (dm_write),
		.dm_address    (dm_address),
		.dm_in         (dm_in),
		.alu_overflow  (alu_overflow),
		.end_run       (end_run),
		.stores_done   (stores_done),
		.report_done   (report_done),
		.error_count   (error_count)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// galois form, shifts right
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 32'h80200003;
		return next;
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic make_program();
		cpu_pkg::instr_u word;
		logic [31:0]     kind;
		logic [31:0]     rt;
		logic [31:0]     ra;
		logic [31:0]     rb;
		logic [31:0]     fn;
		logic [31:0]     imm;
		logic [4:0]      fn_code;
		for (int i = 0; i < PROG_WORDS; i++) begin
			word = '0;
			if (i < RANDOM_WORDS) begin
				draw_bits(3, kind);
				draw_bits(3, rt);
				word.i_fmt.rt = rt[`CPU_REG_AW-1:0];
				if (kind <= 2) begin
					draw_bits(3, ra);
					draw_bits(3, rb);
					draw_bits(3, fn);
					fn_code = 5'(fn % 5);
					word.r_fmt.opcode = cpu_pkg::alu_r;
					word.r_fmt.ra = ra[`CPU_REG_AW-1:0];
					word.r_fmt.rb = rb[`CPU_REG_AW-1:0];
					word.r_fmt.fn = cpu_pkg::alu_fn_t'(fn_code);
				end else if (kind == 3 || kind == 4 || kind == 7) begin
					draw_bits(3, ra);
					draw_bits(16, imm);
					word.i_fmt.opcode = (kind == 4) ? cpu_pkg::ori : cpu_pkg::addi;
					word.i_fmt.ra = ra[`CPU_REG_AW-1:0];
					word.i_fmt.imm = imm[15:0];
				end else begin
					// base r0, small offset
					draw_bits(6, imm);
					word.i_fmt.opcode = (kind == 5) ? cpu_pkg::lw : cpu_pkg::sw;
					word.i_fmt.imm = imm[15:0];
				end
			end else if (i < RANDOM_WORDS + 7) begin
				// dump r1..r7 to words 64..70
				word.i_fmt.opcode = cpu_pkg::sw;
				word.i_fmt.rt = 5'(i - RANDOM_WORDS + 1);
				word.i_fmt.imm = 16'(64 + i - RANDOM_WORDS);
			end
			program_words[i] = word;
		end
	endtask

	// memories answer within the cycle, inputs move on the falling edge
	always @(negedge clk) begin
		if (int'(im_address) < PROG_WORDS)
			instruction = program_words[im_address];
		else
			instruction = '0;
		dm_out = data_mem[dm_address];
	end

	always @(posedge clk) begin
		if (rst_n && dm_write)
			data_mem[dm_address] <= dm_in;
	end

	initial begin
		rst_n = 1'b0;
		for (int k = 0; k < DM_WORDS; k++)
			data_mem[k] = k ^ 32'h5a5a0000;
		make_program();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		prog_ready = 1'b1;
		while (!(stores_done && int'(im_address) >= DRAIN_PC) &&
			cycle_count < TIMEOUT_CYCLES)
			@(posedge clk);
		if (cycle_count >= TIMEOUT_CYCLES) begin
			timed_out = 1'b1;
			$display("timeout after %0d cycles with stores still outstanding", cycle_count);
		end
		end_run = 1'b1;
		wait (report_done);
		if (error_count == 0 && !timed_out)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+include
source/cpu_pkg.sv
source/alu.sv
source/regfile.sv
source/controller.sv
source/regwalls.sv
source/cpu_top.sv
test/cpu_properties.sv
test/cpu_checker.sv
test/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Testbench failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
